// File: rtl/tank_pkg.sv
// tank arena package: shared types, vga timing, arena limits, key and color tables
package tank_pkg;

  // ===================================================================
  // types
  // ===================================================================
  typedef logic [9:0]        coord_t;     // screen x or y
  typedef logic [4:0]        heading_t;   // 32-step wheel, 0 is +x
  typedef logic signed [7:0] trig_t;      // sin/cos scaled by 64
  typedef logic [7:0]        keycode_t;   // one hid usage code
  typedef logic [31:0]       key_word_t;  // four keycodes from the usb host

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

  typedef struct packed {
    coord_t   x;
    coord_t   y;
    heading_t heading;
    coord_t   tip_x;     // barrel end
    coord_t   tip_y;
  } tank_state_t;

  // ===================================================================
  // 640x480 timing, sync active low
  // ===================================================================
  localparam int H_VISIBLE = 640;
  localparam int H_FRONT   = 16;
  localparam int H_SYNC    = 96;
  localparam int H_TOTAL   = 800;
  localparam int V_VISIBLE = 480;
  localparam int V_FRONT   = 10;
  localparam int V_SYNC    = 2;
  localparam int V_TOTAL   = 525;

  // ===================================================================
  // game geometry
  // ===================================================================
  localparam int TANK_HALF   = 8;
  localparam int BARREL_LEN  = 16;
  localparam int TIP_HALF    = 2;
  localparam int MOVE_SHIFT  = 5;    // step of at most 2 px per frame
  localparam int ARENA_MIN   = 16;
  localparam int ARENA_MAX_X = 623;
  localparam int ARENA_MAX_Y = 463;

  // start centers, indexed by player
  localparam coord_t START_X [2] = '{coord_t'(160), coord_t'(480)};
  localparam coord_t START_Y [2] = '{coord_t'(240), coord_t'(240)};

  // player 0 wasd, player 1 arrow keys
  localparam keycode_t KEY_FWD   [2] = '{8'h1A, 8'h52};
  localparam keycode_t KEY_BACK  [2] = '{8'h16, 8'h51};
  localparam keycode_t KEY_LEFT  [2] = '{8'h04, 8'h50};
  localparam keycode_t KEY_RIGHT [2] = '{8'h07, 8'h4F};

  // palette
  localparam rgb_t COLOR_TANK0 = '{8'h00, 8'hFF, 8'h00};
  localparam rgb_t COLOR_TANK1 = '{8'hFF, 8'h00, 8'h00};
  localparam rgb_t COLOR_TIP   = '{8'hFF, 8'hFF, 8'hFF};
  localparam rgb_t COLOR_FLOOR = '{8'h20, 8'h20, 8'h20};

endpackage

// File: rtl/vga_timing.sv
// vga timing generator: pixel/line counters, sync, blanking and frame tick
module vga_timing (
  input  logic             clk,
  input  logic             rst_n,
  output tank_pkg::coord_t draw_x,
  output tank_pkg::coord_t draw_y,
  output logic             hs,
  output logic             vs,
  output logic             blank,
  output logic             frame_tick
);

  tank_pkg::coord_t h_cnt;
  tank_pkg::coord_t v_cnt;
  logic             h_last;
  logic             v_last;

  // end of line / end of frame
  assign h_last = (h_cnt == tank_pkg::coord_t'(tank_pkg::H_TOTAL - 1));
  assign v_last = (v_cnt == tank_pkg::coord_t'(tank_pkg::V_TOTAL - 1));

  // ===================================================================
  // counters
  // ===================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else begin
      if (h_last) begin
        h_cnt <= '0;
        // line advances only on x wrap
        if (v_last) begin
          v_cnt <= '0;
        end else begin
          v_cnt <= v_cnt + 10'd1;
        end
      end else begin
        h_cnt <= h_cnt + 10'd1;
      end
    end
  end

  // ===================================================================
  // decode, all combinational from the counters
  // ===================================================================
  // hs low 656..751
  assign hs = !((h_cnt >= tank_pkg::coord_t'(tank_pkg::H_VISIBLE + tank_pkg::H_FRONT)) &&
                (h_cnt <  tank_pkg::coord_t'(tank_pkg::H_VISIBLE + tank_pkg::H_FRONT +
                                             tank_pkg::H_SYNC)));
  // vs low on lines 490 and 491
  assign vs = !((v_cnt >= tank_pkg::coord_t'(tank_pkg::V_VISIBLE + tank_pkg::V_FRONT)) &&
                (v_cnt <  tank_pkg::coord_t'(tank_pkg::V_VISIBLE + tank_pkg::V_FRONT +
                                             tank_pkg::V_SYNC)));

  assign blank = (h_cnt >= tank_pkg::coord_t'(tank_pkg::H_VISIBLE)) ||
                 (v_cnt >= tank_pkg::coord_t'(tank_pkg::V_VISIBLE));

  // one pulse on the last visible pixel
  assign frame_tick = (h_cnt == tank_pkg::coord_t'(tank_pkg::H_VISIBLE - 1)) &&
                      (v_cnt == tank_pkg::coord_t'(tank_pkg::V_VISIBLE - 1));

  assign draw_x = h_cnt;
  assign draw_y = v_cnt;

endmodule

// File: rtl/sin_cos_rom.sv
// sine/cosine lookup for a 32-step heading, quarter-wave table with folding
module sin_cos_rom (
  input  tank_pkg::heading_t heading,
  output tank_pkg::trig_t    sin,
  output tank_pkg::trig_t    cos
);

  tank_pkg::heading_t cos_head;

  // round(64*sin(k*pi/16)), k = 0..8
  function automatic logic [7:0] quarter(input logic [3:0] k);
    case (k)
      4'd0:    return 8'd0;
      4'd1:    return 8'd12;
      4'd2:    return 8'd24;
      4'd3:    return 8'd36;
      4'd4:    return 8'd45;
      4'd5:    return 8'd53;
      4'd6:    return 8'd59;
      4'd7:    return 8'd63;
      default: return 8'd64;
    endcase
  endfunction

  // bit 3 mirrors within the quadrant, bit 4 negates
  function automatic tank_pkg::trig_t fold_sin(input tank_pkg::heading_t h);
    logic [3:0] idx;
    logic [7:0] mag;
    idx = h[3] ? (4'd8 - {1'b0, h[2:0]}) : {1'b0, h[2:0]};
    mag = quarter(idx);
    return h[4] ? tank_pkg::trig_t'(-mag) : tank_pkg::trig_t'(mag);
  endfunction

  // cos(h) = sin(h + quarter turn), wraps mod 32
  assign cos_head = heading + 5'd8;

  assign sin = fold_sin(heading);
  assign cos = fold_sin(cos_head);

endmodule

// File: rtl/tank_motion.sv
// tank motion: key decode, heading and clamped position per frame, barrel tip
module tank_motion #(
  parameter int PLAYER = 0
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  frame_tick,
  input  tank_pkg::key_word_t   keycode,
  output tank_pkg::tank_state_t tank
);

  logic               key_fwd, key_back, key_left, key_right;
  logic               go_fwd, go_back, turn_l, turn_r;
  logic               tip_due;
  tank_pkg::trig_t    sin_val, cos_val;
  tank_pkg::trig_t    step_x, step_y;
  logic signed [11:0] dx, dy;
  logic signed [11:0] raw_x, raw_y;
  logic signed [15:0] tip_off_x, tip_off_y;
  tank_pkg::heading_t next_heading;

  // key is down if any of the four report bytes carries it
  function automatic logic key_hit(input tank_pkg::key_word_t word,
                                   input tank_pkg::keycode_t  key);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (word[8*i +: 8] == key) hit = 1'b1;
    end
    return hit;
  endfunction

  // keep the center inside the arena
  function automatic tank_pkg::coord_t clamp(input logic signed [11:0] v, input int hi);
    if (v < tank_pkg::ARENA_MIN) return tank_pkg::coord_t'(tank_pkg::ARENA_MIN);
    if (v > hi) return tank_pkg::coord_t'(hi);
    return v[9:0];
  endfunction

  // ===================================================================
  // key decode
  // ===================================================================
  assign key_fwd   = key_hit(keycode, tank_pkg::KEY_FWD[PLAYER]);
  assign key_back  = key_hit(keycode, tank_pkg::KEY_BACK[PLAYER]);
  assign key_left  = key_hit(keycode, tank_pkg::KEY_LEFT[PLAYER]);
  assign key_right = key_hit(keycode, tank_pkg::KEY_RIGHT[PLAYER]);

  // opposing keys cancel
  assign go_fwd  = key_fwd & ~key_back;
  assign go_back = key_back & ~key_fwd;
  assign turn_r  = key_right & ~key_left;
  assign turn_l  = key_left & ~key_right;

  // ===================================================================
  // motion math
  // ===================================================================
  // rom follows the heading register: old heading on the tick cycle,
  // new heading on the cycle after
  sin_cos_rom u_trig (
    .heading (tank.heading),
    .sin     (sin_val),
    .cos     (cos_val)
  );

  assign step_x = cos_val >>> tank_pkg::MOVE_SHIFT;
  assign step_y = sin_val >>> tank_pkg::MOVE_SHIFT;

  // back is the shifted step negated
  assign dx = go_fwd ? 12'(step_x) : (go_back ? -12'(step_x) : 12'sd0);
  assign dy = go_fwd ? 12'(step_y) : (go_back ? -12'(step_y) : 12'sd0);

  assign raw_x = $signed({2'b00, tank.x}) + dx;
  assign raw_y = $signed({2'b00, tank.y}) + dy;

  assign next_heading = turn_r ? tank.heading + 5'd1 :
                        (turn_l ? tank.heading - 5'd1 : tank.heading);

  // barrel offset, table scale 64 removed by the shift
  assign tip_off_x = (16'(cos_val) * 16'(tank_pkg::BARREL_LEN)) >>> 6;
  assign tip_off_y = (16'(sin_val) * 16'(tank_pkg::BARREL_LEN)) >>> 6;

  // ===================================================================
  // state
  // ===================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tank.x       <= tank_pkg::START_X[PLAYER];
      tank.y       <= tank_pkg::START_Y[PLAYER];
      // player 1 faces -x
      tank.heading <= tank_pkg::heading_t'(PLAYER * 16);
      tank.tip_x   <= (PLAYER == 0) ?
                      tank_pkg::START_X[PLAYER] + tank_pkg::coord_t'(tank_pkg::BARREL_LEN) :
                      tank_pkg::START_X[PLAYER] - tank_pkg::coord_t'(tank_pkg::BARREL_LEN);
      tank.tip_y   <= tank_pkg::START_Y[PLAYER];
      tip_due      <= 1'b0;
    end else begin
      tip_due <= frame_tick;
      if (frame_tick) begin
        tank.heading <= next_heading;
        tank.x       <= clamp(raw_x, tank_pkg::ARENA_MAX_X);
        tank.y       <= clamp(raw_y, tank_pkg::ARENA_MAX_Y);
      end
      // tip one cycle after the move, from the new center and heading
      if (tip_due) begin
        tank.tip_x <= tank_pkg::coord_t'($signed({6'b0, tank.x}) + tip_off_x);
        tank.tip_y <= tank_pkg::coord_t'($signed({6'b0, tank.y}) + tip_off_y);
      end
    end
  end

endmodule

// File: rtl/arena_renderer.sv
// arena renderer: colors each pixel from two tank states, registered with sync
module arena_renderer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  tank_pkg::coord_t      draw_x,
  input  tank_pkg::coord_t      draw_y,
  input  logic                  blank,
  input  logic                  hs,
  input  logic                  vs,
  input  tank_pkg::tank_state_t tank0,
  input  tank_pkg::tank_state_t tank1,
  output tank_pkg::rgb_t        pixel,
  output logic                  vga_hs,
  output logic                  vga_vs
);

  logic           hit_tip0, hit_tip1;
  logic           hit_body0, hit_body1;
  tank_pkg::rgb_t color;

  // square window test, both axis distances within half
  function automatic logic in_box(input tank_pkg::coord_t px, py, cx, cy,
                                  input int half);
    logic signed [10:0] dx;
    logic signed [10:0] dy;
    dx = $signed({1'b0, px}) - $signed({1'b0, cx});
    dy = $signed({1'b0, py}) - $signed({1'b0, cy});
    return (dx <= half) && (dx >= -half) && (dy <= half) && (dy >= -half);
  endfunction

  // ===================================================================
  // window tests
  // ===================================================================
  assign hit_tip0  = in_box(draw_x, draw_y, tank0.tip_x, tank0.tip_y, tank_pkg::TIP_HALF);
  assign hit_tip1  = in_box(draw_x, draw_y, tank1.tip_x, tank1.tip_y, tank_pkg::TIP_HALF);
  assign hit_body0 = in_box(draw_x, draw_y, tank0.x, tank0.y, tank_pkg::TANK_HALF);
  assign hit_body1 = in_box(draw_x, draw_y, tank1.x, tank1.y, tank_pkg::TANK_HALF);

  // fixed priority, tips over bodies, tank 0 over tank 1
  always_comb begin
    if (blank) begin
      color = '0;
    end else if (hit_tip0 || hit_tip1) begin
      color = tank_pkg::COLOR_TIP;
    end else if (hit_body0) begin
      color = tank_pkg::COLOR_TANK0;
    end else if (hit_body1) begin
      color = tank_pkg::COLOR_TANK1;
    end else begin
      color = tank_pkg::COLOR_FLOOR;
    end
  end

  // ===================================================================
  // output stage, sync delayed with the color
  // ===================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pixel  <= '0;
      vga_hs <= 1'b1;
      vga_vs <= 1'b1;
    end else begin
      pixel  <= color;
      vga_hs <= hs;
      vga_vs <= vs;
    end
  end

endmodule

// File: rtl/tank_arena.sv
// tank arena top: vga timing, two tank motion blocks and the pixel renderer
module tank_arena (
  input  logic                clk,
  input  logic                rst_n,
  input  tank_pkg::key_word_t keycode,
  output tank_pkg::rgb_t      pixel,
  output logic                vga_hs,
  output logic                vga_vs
);

  tank_pkg::coord_t      draw_x;
  tank_pkg::coord_t      draw_y;
  logic                  hs;
  logic                  vs;
  logic                  blank;
  logic                  frame_tick;
  tank_pkg::tank_state_t tank0;
  tank_pkg::tank_state_t tank1;

  // raster position and frame pulse
  vga_timing u_timing (
    .clk        (clk),
    .rst_n      (rst_n),
    .draw_x     (draw_x),
    .draw_y     (draw_y),
    .hs         (hs),
    .vs         (vs),
    .blank      (blank),
    .frame_tick (frame_tick)
  );

  // player 0, wasd
  tank_motion #(.PLAYER(0)) u_tank0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .frame_tick (frame_tick),
    .keycode    (keycode),
    .tank       (tank0)
  );

  // player 1, arrows
  tank_motion #(.PLAYER(1)) u_tank1 (
    .clk        (clk),
    .rst_n      (rst_n),
    .frame_tick (frame_tick),
    .keycode    (keycode),
    .tank       (tank1)
  );

  arena_renderer u_render (
    .clk    (clk),
    .rst_n  (rst_n),
    .draw_x (draw_x),
    .draw_y (draw_y),
    .blank  (blank),
    .hs     (hs),
    .vs     (vs),
    .tank0  (tank0),
    .tank1  (tank1),
    .pixel  (pixel),
    .vga_hs (vga_hs),
    .vga_vs (vga_vs)
  );

endmodule

// File: tests/tb_clock_gen.sv
// testbench clock and reset source: 100 ns clock, reset held low for 16 cycles
module tb_clock_gen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ns;

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // release on a falling edge, away from the dut's sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// File: tests/tank_arena_sva.sv
// renderer assertions: hsync pulse width, single-cycle frame tick, black pixel in blanking
module tank_arena_sva (
  input logic             clk,
  input logic             rst_n,
  input tank_pkg::coord_t draw_x,
  input tank_pkg::coord_t draw_y,
  input logic             hs,
  input logic             blank,
  input tank_pkg::rgb_t   pixel
);
  timeunit 1ns;
  timeprecision 1ns;

  logic       tick;
  logic [9:0] hs_low_cnt;

  // frame tick as decoded from the raster position
  assign tick = (draw_x == tank_pkg::coord_t'(tank_pkg::H_VISIBLE - 1)) &&
                (draw_y == tank_pkg::coord_t'(tank_pkg::V_VISIBLE - 1));

  // length of the current hsync low phase
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hs_low_cnt <= '0;
    end else if (!hs) begin
      hs_low_cnt <= hs_low_cnt + 10'd1;
    end else begin
      hs_low_cnt <= '0;
    end
  end

  // ===================================================================
  // properties
  // ===================================================================
  a_hs_width: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(hs) |-> (hs_low_cnt == 10'(tank_pkg::H_SYNC)))
    else $error("hsync low phase did not last exactly 96 cycles");

  // never longer than the sync width either
  a_hs_max: assert property (@(posedge clk) disable iff (!rst_n)
    !hs |-> (hs_low_cnt < 10'(tank_pkg::H_SYNC)))
    else $error("hsync low phase longer than 96 cycles");

  a_tick_single: assert property (@(posedge clk) disable iff (!rst_n)
    tick |=> !tick)
    else $error("frame tick high on two consecutive cycles");

  a_blank_black: assert property (@(posedge clk) disable iff (!rst_n)
    blank |=> (pixel == '0))
    else $error("pixel not black one cycle after blanking");

endmodule

bind arena_renderer tank_arena_sva i_sva (
  .clk    (clk),
  .rst_n  (rst_n),
  .draw_x (draw_x),
  .draw_y (draw_y),
  .hs     (hs),
  .blank  (blank),
  .pixel  (pixel)
);

// File: tests/tank_arena_tb.sv
// tank arena testbench: random keycodes per frame against a model of raster, tanks and colors
module tank_arena_tb;
  timeunit 1ns;
  timeprecision 1ns;

  localparam int FRAME_CYCLES   = tank_pkg::H_TOTAL * tank_pkg::V_TOTAL;
  localparam int RUN_FRAMES     = 8;
  localparam int RUN_CYCLES     = RUN_FRAMES * FRAME_CYCLES;
  localparam int TIMEOUT_CYCLES = RUN_CYCLES + 1000;

  // round(64*sin(k*pi/16)), k = 0..8
  localparam int QUARTER [9] = '{0, 12, 24, 36, 45, 53, 59, 63, 64};
  // fwd, back, left, right for player 0, then player 1
  localparam logic [7:0] GAME_KEYS [8] = '{8'h1A, 8'h16, 8'h04, 8'h07,
                                          8'h52, 8'h51, 8'h50, 8'h4F};

  localparam tank_pkg::rgb_t BLACK = 24'h000000;
  localparam tank_pkg::rgb_t GREEN = 24'h00FF00;
  localparam tank_pkg::rgb_t RED   = 24'hFF0000;
  localparam tank_pkg::rgb_t WHITE = 24'hFFFFFF;
  localparam tank_pkg::rgb_t GREY  = 24'h202020;

  logic                  clk;
  logic                  rst_n;
  tank_pkg::key_word_t   keycode;
  tank_pkg::rgb_t        pixel;
  logic                  vga_hs;
  logic                  vga_vs;

  logic [31:0]           lcg_state;
  int                    cycles = 0;
  int                    frames;
  int                    cnt_x;
  int                    cnt_y;
  int                    at_x;
  int                    at_y;
  tank_pkg::tank_state_t m_tank [2];
  tank_pkg::rgb_t        exp_pixel;
  logic                  exp_hs;
  logic                  exp_vs;

  tb_clock_gen i_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  tank_arena i_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .keycode (keycode),
    .pixel   (pixel),
    .vga_hs  (vga_hs),
    .vga_vs  (vga_vs)
  );

  // ===================================================================
  // stimulus
  // ===================================================================
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // per byte: empty, a game key (most often) or some other code
  function automatic tank_pkg::key_word_t random_key_word();
    tank_pkg::key_word_t w;
    logic [31:0]         r;
    for (int i = 0; i < 4; i++) begin
      r = lcg_next();
      case (r[29:28])
        2'd0:    w[8*i +: 8] = 8'h00;
        2'd3:    w[8*i +: 8] = r[23:16];
        default: w[8*i +: 8] = GAME_KEYS[r[18:16]];
      endcase
    end
    return w;
  endfunction

  // ===================================================================
  // reference model
  // ===================================================================
  function automatic int sin_of(input int h);
    int r;
    r = h % 8;
    // quadrant picks mirror and sign
    case (h / 8)
      0:       return QUARTER[r];
      1:       return QUARTER[8 - r];
      2:       return -QUARTER[r];
      default: return -QUARTER[8 - r];
    endcase
  endfunction

  function automatic int cos_of(input int h);
    return sin_of((h + 8) % 32);
  endfunction

  function automatic bit key_down(input tank_pkg::key_word_t w, input logic [7:0] key);
    bit hit;
    hit = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (w[8*i +: 8] == key) hit = 1'b1;
    end
    return hit;
  endfunction

  function automatic int clamp_int(input int v, input int lo, input int hi);
    return (v < lo) ? lo : ((v > hi) ? hi : v);
  endfunction

  // barrel end from center and heading
  function automatic tank_pkg::tank_state_t with_tip(input tank_pkg::tank_state_t t);
    tank_pkg::tank_state_t n;
    n = t;
    n.tip_x = tank_pkg::coord_t'(int'(t.x) + ((cos_of(int'(t.heading)) * 16) >>> 6));
    n.tip_y = tank_pkg::coord_t'(int'(t.y) + ((sin_of(int'(t.heading)) * 16) >>> 6));
    return n;
  endfunction

  function automatic tank_pkg::tank_state_t start_tank(input int player);
    tank_pkg::tank_state_t t;
    t = '0;
    t.x = (player == 0) ? 10'd160 : 10'd480;
    t.y = 10'd240;
    t.heading = (player == 0) ? 5'd0 : 5'd16;
    return with_tip(t);
  endfunction

  // one frame step: move along the old heading, then turn
  function automatic tank_pkg::tank_state_t step_tank(input tank_pkg::tank_state_t t,
                                                      input int player,
                                                      input tank_pkg::key_word_t w);
    tank_pkg::tank_state_t n;
    int                    dir;
    int                    turn;
    int                    h;
    dir  = int'(key_down(w, GAME_KEYS[4*player]))     - int'(key_down(w, GAME_KEYS[4*player+1]));
    turn = int'(key_down(w, GAME_KEYS[4*player+3]))   - int'(key_down(w, GAME_KEYS[4*player+2]));
    h    = int'(t.heading);
    n = t;
    n.x = tank_pkg::coord_t'(clamp_int(int'(t.x) + dir * (cos_of(h) >>> 5), 16, 623));
    n.y = tank_pkg::coord_t'(clamp_int(int'(t.y) + dir * (sin_of(h) >>> 5), 16, 463));
    n.heading = tank_pkg::heading_t'((h + turn + 32) % 32);
    return with_tip(n);
  endfunction

  function automatic bit in_window(input int px, py, cx, cy, half);
    return (px - cx <= half) && (cx - px <= half) && (py - cy <= half) && (cy - py <= half);
  endfunction

  function automatic tank_pkg::rgb_t predict_color(input int x, input int y);
    if (x >= 640 || y >= 480) return BLACK;
    if (in_window(x, y, m_tank[0].tip_x, m_tank[0].tip_y, 2)) return WHITE;
    if (in_window(x, y, m_tank[1].tip_x, m_tank[1].tip_y, 2)) return WHITE;
    if (in_window(x, y, m_tank[0].x, m_tank[0].y, 8)) return GREEN;
    if (in_window(x, y, m_tank[1].x, m_tank[1].y, 8)) return RED;
    return GREY;
  endfunction

  // outputs for the counter value just clocked, then advance the model
  task automatic model_cycle(output bit tick);
    at_x      = cnt_x;
    at_y      = cnt_y;
    exp_pixel = predict_color(cnt_x, cnt_y);
    exp_hs    = !((cnt_x >= 656) && (cnt_x <= 751));
    exp_vs    = !((cnt_y == 490) || (cnt_y == 491));
    tick      = (cnt_x == 639) && (cnt_y == 479);
    if (tick) begin
      for (int p = 0; p < 2; p++) m_tank[p] = step_tank(m_tank[p], p, keycode);
    end
    cnt_x = (cnt_x + 1) % 800;
    if (cnt_x == 0) cnt_y = (cnt_y + 1) % 525;
  endtask

  // ===================================================================
  // checks
  // ===================================================================
  task automatic check_pixel(input tank_pkg::rgb_t got, input tank_pkg::rgb_t exp);
    if (got !== exp) begin
      $display("ERR t=%0t pixel got %06h exp %06h at x=%0d y=%0d",
               $time, got, exp, at_x, at_y);
      $display("Simulation failed");
      $fatal(1, "pixel mismatch");
    end
  endtask

  task automatic check_sync(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got %b exp %b at x=%0d y=%0d",
               $time, name, got, exp, at_x, at_y);
      $display("Simulation failed");
      $fatal(1, "sync mismatch");
    end
  endtask

  // run limit in clock cycles
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Simulation failed");
      $fatal(1, "timeout, run still going after %0d cycles", cycles);
    end
  end

  initial begin
    bit tick;
    keycode   = '0;
    lcg_state = 32'h3875;
    frames    = 0;
    cnt_x     = 0;
    cnt_y     = 0;
    at_x      = 0;
    at_y      = 0;
    for (int p = 0; p < 2; p++) m_tank[p] = start_tank(p);

    // reset values, sync idle high and black
    @(posedge rst_n);
    check_pixel(pixel, BLACK);
    check_sync("vga_hs", vga_hs, 1'b1);
    check_sync("vga_vs", vga_vs, 1'b1);

    for (int c = 0; c < RUN_CYCLES; c++) begin
      @(negedge clk);
      model_cycle(tick);
      check_pixel(pixel, exp_pixel);
      check_sync("vga_hs", vga_hs, exp_hs);
      check_sync("vga_vs", vga_vs, exp_vs);
      // new keys right after the tick that consumed the old ones
      if (tick) begin
        frames++;
        $display("frame %0d keys %08h tank0 (%0d,%0d) h%0d tank1 (%0d,%0d) h%0d", frames,
                 keycode, m_tank[0].x, m_tank[0].y, m_tank[0].heading,
                 m_tank[1].x, m_tank[1].y, m_tank[1].heading);
        keycode = random_key_word();
      end
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

// File: tank_arena.f
rtl/tank_pkg.sv
rtl/vga_timing.sv
rtl/sin_cos_rom.sv
rtl/tank_motion.sv
rtl/arena_renderer.sv
rtl/tank_arena.sv
tests/tb_clock_gen.sv
tests/tank_arena_sva.sv
tests/tank_arena_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
TOP       := tank_arena_tb
FILELIST  := tank_arena.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
